//--- Makefile
VERILATOR   ?= verilator
FILELIST    ?= project.f
TB_TOP      ?= tb_rv_core
RTL_TOP     ?= rv_core
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
EXTRA_FLAGS ?=

VFLAGS := --timing --assert $(EXTRA_FLAGS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- project.f
+incdir+verilog
+incdir+sim
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_reg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/hazard_unit.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

//--- sim/tb_tests.svh
// directed tests included into tb_rv_core; stores go to 0x100 upward and x10 holds that base
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

  localparam logic [31:0] ECALL_WORD = 32'h0000_0073;

  // RV32I encoders truncate each field to its width
  function automatic logic [31:0] alu_rr(int f7, int f3, int rd, int rs1, int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_i(int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] load_word(int rd, int rs1, int off);
    return {12'(off), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
  endfunction

  function automatic logic [31:0] store_word(int rs2, int rs1, int off);
    logic [11:0] o;
    o = 12'(off);
    return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(int f3, int rs1, int rs2, int off); // f3 is 0 for beq
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jump_link(int rd, int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  task automatic new_program(string name);
    cur_test        = name;
    errors_at_start = errors;
    prog_len        = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[8'(i)] = 32'h0000_0013; // addi x0, x0, 0
      dmem[8'(i)] <= fill_word(i);
    end
    st_addr.delete();
    st_data.delete();
  endtask

  task automatic emit(logic [31:0] word);
    imem[8'(prog_len)] = word;
    prog_len++;
  endtask

  task automatic end_program();
    emit(addi_i(17, 0, 10)); // halt code
    emit(ECALL_WORD);
  endtask

  // dependent add sub and or slt back to back with results stored newest first
  task automatic arith_forwarding_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expv [5];
    new_program("arith_forwarding");
    a       = rand_imm12();
    b       = rand_imm12();
    expv[4] = a + b;                 // x3
    expv[3] = a - expv[4];           // x4
    expv[2] = expv[3] & a;           // x5
    expv[1] = expv[2] | b;           // x6
    expv[0] = ($signed(expv[1]) < $signed(expv[3])) ? 32'd1 : 32'd0; // x7
    emit(addi_i(10, 0, 256));
    emit(addi_i(1, 0, int'(a)));
    emit(addi_i(2, 0, int'(b)));
    emit(alu_rr(7'h00, 3'h0, 3, 1, 2)); // add
    emit(alu_rr(7'h20, 3'h0, 4, 1, 3)); // sub
    emit(alu_rr(7'h00, 3'h7, 5, 4, 1)); // and
    emit(alu_rr(7'h00, 3'h6, 6, 5, 2)); // or
    emit(alu_rr(7'h00, 3'h2, 7, 6, 4)); // slt
    for (int r = 7; r >= 3; r--) begin
      emit(store_word(r, 10, 4 * (r - 3))); // x7 store data forwarded from mem
    end
    end_program();
    run_program();
    check_value("store count", 32'd5, 32'(st_addr.size()));
    for (int i = 0; i < 5; i++) begin
      check_store(i, 256 + 16 - 4 * i, expv[i]);
    end
    check_value("data word 64", expv[4], dmem[64]);
    finish_test();
  endtask

  task automatic load_use_test();
    logic [31:0] v;
    logic [31:0] c;
    new_program("load_use");
    v = rand_imm12();
    c = rand_imm12(); // addend
    emit(addi_i(10, 0, 256));
    emit(addi_i(1, 0, int'(v)));
    emit(addi_i(4, 0, int'(c)));
    emit(store_word(1, 10, 0));
    emit(load_word(2, 10, 0));
    emit(alu_rr(7'h00, 3'h0, 3, 2, 4)); // load in rs1 costs one bubble
    emit(store_word(3, 10, 4));
    emit(load_word(6, 10, 0));
    emit(store_word(6, 10, 8));         // load in store data
    end_program();
    run_program();
    check_value("store count", 32'd3, 32'(st_addr.size()));
    check_store(0, 256, v);
    check_store(1, 260, v + c);
    check_store(2, 264, v);
    check_value("data word 65", v + c, dmem[65]);
    finish_test();
  endtask

  // markers 1..7 sit in x20..x26 and only those on the taken path may be stored
  task automatic branch_test();
    new_program("branches");
    emit(addi_i(10, 0, 256));
    for (int m = 1; m <= 7; m++) begin
      emit(addi_i(19 + m, 0, m));
    end
    emit(addi_i(1, 0, 5));
    emit(addi_i(2, 0, 5));
    emit(addi_i(3, 0, 7));
    emit(branch(0, 1, 2, 12));   // taken beq skips markers 1 and 2
    emit(store_word(20, 10, 0));
    emit(store_word(21, 10, 4));
    emit(store_word(22, 10, 8));
    emit(branch(0, 1, 3, 8));    // beq not taken
    emit(store_word(23, 10, 12));
    emit(branch(1, 1, 3, 8));    // taken bne skips marker 5
    emit(store_word(24, 10, 16));
    emit(store_word(25, 10, 20));
    emit(branch(1, 1, 2, 8));    // bne not taken
    emit(store_word(26, 10, 24));
    end_program();
    run_program();
    check_value("store count", 32'd4, 32'(st_addr.size()));
    check_store(0, 264, 32'd3);
    check_store(1, 268, 32'd4);
    check_store(2, 276, 32'd6);
    check_store(3, 280, 32'd7);
    finish_test();
  endtask

  task automatic jal_test();
    int jal_pc;
    new_program("jal");
    emit(addi_i(10, 0, 256));
    emit(addi_i(20, 0, 1));
    emit(addi_i(21, 0, 2));
    jal_pc = 4 * prog_len;
    emit(jump_link(5, 12));      // over two stores
    emit(store_word(20, 10, 0));
    emit(store_word(21, 10, 4));
    emit(store_word(5, 10, 8));  // link value
    end_program();
    run_program();
    check_value("store count", 32'd1, 32'(st_addr.size()));
    check_store(0, 264, 32'(jal_pc + 4));
    check_value("skipped word 64", fill_word(64), dmem[64]);
    finish_test();
  endtask

  task automatic halt_test();
    int frozen_pc;
    new_program("halt");
    emit(addi_i(10, 0, 256));
    emit(addi_i(20, 0, 'h55));
    emit(addi_i(17, 0, 3));
    emit(ECALL_WORD);            // x17 is 3 so the core keeps running
    emit(store_word(20, 10, 0));
    end_program();
    frozen_pc = 4 * (prog_len + 3); // fetch sits four words past the ecall in writeback
    emit(store_word(20, 10, 4)); // behind the halting ecall
    emit(store_word(20, 10, 8));
    run_program();
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_true(halted === 1'b1, "halted dropped before reset");
      check_value("frozen pc", 32'(frozen_pc), imem_req.addr);
    end
    check_value("store count", 32'd1, 32'(st_addr.size()));
    check_store(0, 256, 32'h55);
    check_value("data word 65", fill_word(65), dmem[65]);
    check_value("data word 66", fill_word(66), dmem[66]);
    finish_test();
  endtask

`endif

//--- sim/tb_rv_core.sv
// testbench for rv_core; imem and dmem are 256 words each, answer combinationally, code starts at 0
`include "core_defs.svh"
`default_nettype none

module tb_rv_core;
  import pipe_pkg::*;

  localparam int MEM_WORDS   = 256; // 8-bit word index
  localparam int HOLD_CYCLES = 20;  // watched after halt

  logic      clk;
  logic      reset;
  imem_req_t imem_req;
  imem_rsp_t imem_rsp;
  dmem_req_t dmem_req;
  dmem_rsp_t dmem_rsp;
  logic      halted;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] st_addr [$]; // store log in issue order
  logic [31:0] st_data [$];

  logic [31:0] rng;
  string       cur_test;
  int          prog_len;     // words in current program
  int          total_words;  // all programs so far
  int          run_cycles;   // cycles out of reset
  int          checks;
  int          errors;
  int          errors_at_start;
  int          tests;

  rv_core i_dut (
    .clk(clk), .reset(reset), .imem_rsp(imem_rsp), .imem_req(imem_req),
    .dmem_rsp(dmem_rsp), .dmem_req(dmem_req), .halted(halted)
  );

  assign imem_rsp.instr = imem[imem_req.addr[9:2]]; // same-cycle fetch
  assign dmem_rsp.rdata = dmem_req.rd ? dmem[dmem_req.addr[9:2]] : 'x; // data only on a read

  // every accepted store also goes to the log
  always @(posedge clk) begin
    if (!reset && dmem_req.wr) begin
      dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
      st_addr.push_back(dmem_req.addr);
      st_data.push_back(dmem_req.wdata);
    end
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // watchdog allows 10 cycles per program word plus the post-halt watch
  initial begin
    while (run_cycles <= 10 * total_words + HOLD_CYCLES) begin
      @(posedge clk);
      if (!reset) begin
        run_cycles++;
      end
    end
    $display("timeout: core did not halt after %0d cycles in test %s", run_cycles, cur_test);
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // next random value as a sign-extended 12-bit immediate
  function automatic logic [31:0] rand_imm12();
    rng = xorshift32(rng);
    return {{20{rng[11]}}, rng[11:0]};
  endfunction

  function automatic logic [31:0] fill_word(int idx);
    return 32'hd0d0_0000 | 32'(idx); // whole word index in the low bits
  endfunction

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(logic cond, string what);
    checks++;
    assert (cond) else begin
      $display("error in %s: %s", cur_test, what);
      errors++;
    end
  endtask

  task automatic check_store(int idx, int addr, logic [31:0] data);
    if (idx >= st_addr.size()) begin
      check_true(1'b0, $sformatf("store %0d never happened", idx));
    end else begin
      check_value($sformatf("store %0d address", idx), 32'(addr), st_addr[idx]);
      check_value($sformatf("store %0d data", idx), data, st_data[idx]);
    end
  endtask

  // reset for 8 cycles and run until the core halts
  task automatic run_program();
    total_words += prog_len;
    @(negedge clk);
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test();
    tests++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    reset = 1'b1;
    rng   = 32'h7c20;
    arith_forwarding_test();
    load_use_test();
    branch_test();
    jal_test();
    halt_test();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/core_defs.svh
// core parameters; decoder and immediates assume XLEN of 32, register count must be a power of 2
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`default_nettype none

`define XLEN 32       // data and address width
`define NUM_REGS 32   // architectural integer registers
`define RESET_PC 32'h0000_0000

// ecall halts only when x17 holds 10
`define HALT_REG 5'd17
`define HALT_CODE 32'd10

`default_nettype wire

`endif

//--- verilog/decoder.sv
// decode for the supported subset; other encodings become a nop, XLEN must be 32
`include "core_defs.svh"
`default_nettype none

module decoder (
  input  wire logic [`XLEN-1:0] instr,
  output rv_isa_pkg::ctrl_t     ctrl,
  output rv_isa_pkg::reg_idx_t  rs1,
  output rv_isa_pkg::reg_idx_t  rs2,
  output rv_isa_pkg::reg_idx_t  rd,
  output logic [`XLEN-1:0]      imm
);
  import rv_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       use_rs1; // unused sources read x0 so they never stall
  logic       use_rs2;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];

  always_comb begin
    ctrl    = '0;
    imm     = '0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      OP_R: begin
        ctrl.reg_write = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        case ({funct7, funct3})
          {F7_BASE, F3_ADD_SUB}: ctrl.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD_SUB}:  ctrl.alu_op = ALU_SUB;
          {F7_BASE, F3_AND}:     ctrl.alu_op = ALU_AND;
          {F7_BASE, F3_OR}:      ctrl.alu_op = ALU_OR;
          {F7_BASE, F3_SLT}:     ctrl.alu_op = ALU_SLT;
          default: begin
            ctrl.reg_write = 1'b0; // unsupported r-type
            use_rs1        = 1'b0;
            use_rs2        = 1'b0;
          end
        endcase
      end
      OP_IMM: if (funct3 == F3_ADD_SUB) begin // addi only
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        use_rs1          = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:20]};
      end
      OP_LOAD: if (funct3 == F3_WORD) begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        use_rs1          = 1'b1;
        imm              = {{20{instr[31]}}, instr[31:20]};
      end
      OP_STORE: if (funct3 == F3_WORD) begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        use_rs1          = 1'b1;
        use_rs2          = 1'b1; // store data
        imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end
      OP_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = (funct3 == F3_BNE);
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1; // link
        ctrl.is_jal    = 1'b1;
        imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      OP_SYSTEM: if (instr[31:7] == '0) begin // ecall, not ebreak
        ctrl.is_ecall = 1'b1;
        use_rs1       = 1'b1;
      end
      default: ;
    endcase
  end

  // ecall reads x17 through the normal rs1 path, so forwarding covers it
  assign rs1 = ctrl.is_ecall ? `HALT_REG : (use_rs1 ? instr[19:15] : '0);
  assign rs2 = use_rs2 ? instr[24:20] : '0;

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
// execute stage, combinational; branches and jal resolve here under predict-not-taken
`include "core_defs.svh"
`default_nettype none

module execute_unit (
  input  wire pipe_pkg::id_ex_t   id_ex,
  input  wire pipe_pkg::fwd_sel_e fwd_a,
  input  wire pipe_pkg::fwd_sel_e fwd_b,
  input  wire logic [`XLEN-1:0]   mem_result,
  input  wire logic [`XLEN-1:0]   wb_value,
  output pipe_pkg::ex_mem_t       ex_mem,
  output logic                    redirect,
  output logic [`XLEN-1:0]        target
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;    // forwarded rs2, also store data
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] link;
  logic             taken;

  function automatic logic [`XLEN-1:0] fwd_mux(fwd_sel_e sel, logic [`XLEN-1:0] reg_val,
                                               logic [`XLEN-1:0] mem_val,
                                               logic [`XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_mux(fwd_a, id_ex.rs1_val, mem_result, wb_value);
  assign op_b  = fwd_mux(fwd_b, id_ex.rs2_val, mem_result, wb_value);
  assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_out = op_a - alu_b;
      ALU_AND: alu_out = op_a & alu_b;
      ALU_OR:  alu_out = op_a | alu_b;
      ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_out = op_a + alu_b; // add, addresses, bubbles
    endcase
  end

  assign link   = id_ex.pc + 32'd4;
  assign target = id_ex.pc + id_ex.imm; // branch and jal share the adder

  // beq taken on equal, bne on not equal
  assign taken    = id_ex.ctrl.is_branch && ((op_a == op_b) ^ id_ex.ctrl.branch_ne);
  assign redirect = taken || id_ex.ctrl.is_jal;

  always_comb begin
    ex_mem            = '0;
    ex_mem.reg_write  = id_ex.ctrl.reg_write;
    ex_mem.mem_read   = id_ex.ctrl.mem_read;
    ex_mem.mem_write  = id_ex.ctrl.mem_write;
    ex_mem.is_halt    = id_ex.ctrl.is_ecall && (op_a == `HALT_CODE); // op_a is x17
    ex_mem.rd         = id_ex.rd;
    ex_mem.result     = id_ex.ctrl.is_jal ? link : alu_out;
    ex_mem.store_data = op_b;
  end

endmodule

`default_nettype wire

//--- verilog/hazard_unit.sv
// pipeline control; halt is sticky until reset and freezes every stage
`default_nettype none

module hazard_unit (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire rv_isa_pkg::reg_idx_t id_rs1,
  input  wire rv_isa_pkg::reg_idx_t id_rs2,
  input  wire pipe_pkg::id_ex_t     id_ex_bits,
  input  wire pipe_pkg::ex_mem_t    ex_mem_bits,
  input  wire pipe_pkg::mem_wb_t    mem_wb_bits,
  input  wire logic                 redirect,
  output logic                      pc_en,
  output logic                      if_id_en,
  output logic                      pipe_en,
  output logic                      if_id_flush,
  output logic                      id_ex_flush,
  output pipe_pkg::fwd_sel_e        fwd_a,
  output pipe_pkg::fwd_sel_e        fwd_b,
  output logic                      halted
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic load_use;
  logic freeze;   // halting ecall in writeback, or already halted

  // newest producer first, x0 never forwarded
  function automatic fwd_sel_e pick(reg_idx_t src, ex_mem_t em, mem_wb_t mw);
    if (src == '0) return FWD_REG;
    if (em.reg_write && em.rd == src) return FWD_MEM;
    if (mw.reg_write && mw.rd == src) return FWD_WB;
    return FWD_REG;
  endfunction

  assign fwd_a = pick(id_ex_bits.rs1, ex_mem_bits, mem_wb_bits);
  assign fwd_b = pick(id_ex_bits.rs2, ex_mem_bits, mem_wb_bits);

  assign load_use = id_ex_bits.ctrl.mem_read && (id_ex_bits.rd != '0) &&
                    (id_ex_bits.rd == id_rs1 || id_ex_bits.rd == id_rs2);

  assign freeze = halted || mem_wb_bits.is_halt;

  // load in ex never redirects, so stall and redirect are exclusive
  assign pc_en       = !freeze && !load_use;
  assign if_id_en    = pc_en;
  assign pipe_en     = !freeze;
  assign if_id_flush = redirect && !freeze;
  assign id_ex_flush = (redirect || load_use) && !freeze; // bubble into ex

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (mem_wb_bits.is_halt) begin
      halted <= 1'b1; // sticky
    end
  end

endmodule

`default_nettype wire

//--- verilog/pipe_pkg.sv
// stage payloads; an all-zero payload is a bubble, memories answer in the same cycle
`include "core_defs.svh"
`default_nettype none

package pipe_pkg;

  typedef struct packed {
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
  } if_id_t;

  typedef struct packed {
    rv_isa_pkg::ctrl_t    ctrl;
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     rs1_val; // register file value, before forwarding
    logic [`XLEN-1:0]     rs2_val;
    logic [`XLEN-1:0]     imm;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    rv_isa_pkg::reg_idx_t rd;
  } id_ex_t;

  typedef struct packed {
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 is_halt;    // ecall that saw x17 == 10
    rv_isa_pkg::reg_idx_t rd;
    logic [`XLEN-1:0]     result;     // alu out, link, or dmem address
    logic [`XLEN-1:0]     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                 reg_write;
    logic                 is_halt;
    rv_isa_pkg::reg_idx_t rd;
    logic [`XLEN-1:0]     value;
  } mem_wb_t;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
  } imem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] instr;
  } imem_rsp_t;

  typedef struct packed {
    logic             rd;
    logic             wr;
    logic [`XLEN-1:0] addr;  // byte address, word aligned
    logic [`XLEN-1:0] wdata;
  } dmem_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] rdata;
  } dmem_rsp_t;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0, // value read in decode
    FWD_MEM = 2'd1, // ex/mem result
    FWD_WB  = 2'd2  // writeback value
  } fwd_sel_e;

endpackage

`default_nettype wire

//--- verilog/pipe_reg.sv
// stage register; flush wins over en, and flush or reset loads an all-zero bubble
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     en,
  input  wire logic     flush,
  input  wire payload_t d,
  output payload_t      q
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0; // bubble
    end else if (en) begin
      q <= d;
    end
    // en low holds
  end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
// two read ports, one write port; a same-cycle write is visible on the read ports
`include "core_defs.svh"
`default_nettype none

module reg_file (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire rv_isa_pkg::reg_idx_t rs1,
  input  wire rv_isa_pkg::reg_idx_t rs2,
  input  wire rv_isa_pkg::reg_idx_t rd,
  input  wire logic                 we,
  input  wire logic [`XLEN-1:0]     wdata,
  output logic [`XLEN-1:0]          rdata1,
  output logic [`XLEN-1:0]          rdata2
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             wr_live; // write that actually lands

  assign wr_live = we && (rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[rd] <= wdata; // x0 never written
    end
  end

  // writeback to decode bypass
  assign rdata1 = (wr_live && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (wr_live && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/rv_core.sv
// five-stage RV32I subset core; imem and dmem must answer in the same cycle, no handshake
`include "core_defs.svh"
`default_nettype none

module rv_core (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire pipe_pkg::imem_rsp_t imem_rsp,
  output pipe_pkg::imem_req_t      imem_req,
  input  wire pipe_pkg::dmem_rsp_t dmem_rsp,
  output pipe_pkg::dmem_req_t      dmem_req,
  output logic                     halted
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] target;
  logic             redirect;
  logic             pc_en, if_id_en, pipe_en;
  logic             if_id_flush, id_ex_flush;
  fwd_sel_e         fwd_a, fwd_b;

  if_id_t  if_id_d, if_id_q;
  id_ex_t  id_ex_d, id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  mem_wb_t mem_wb_d, mem_wb_q;

  ctrl_t            id_ctrl;
  reg_idx_t         id_rs1, id_rs2, id_rd;
  logic [`XLEN-1:0] id_imm;
  logic [`XLEN-1:0] rdata1, rdata2;

  // fetch
  assign pc_next = redirect ? target : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (pc_en) begin
      pc <= pc_next; // held on load-use stall and after halt
    end
  end

  assign imem_req.addr = pc;
  assign if_id_d       = '{instr: imem_rsp.instr, pc: pc};

  pipe_reg #(.payload_t(if_id_t)) i_if_id (
    .clk(clk), .reset(reset), .en(if_id_en), .flush(if_id_flush), .d(if_id_d), .q(if_id_q)
  );

  // decode
  decoder i_decoder (
    .instr(if_id_q.instr), .ctrl(id_ctrl), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm)
  );

  reg_file i_reg_file (
    .clk(clk), .reset(reset), .rs1(id_rs1), .rs2(id_rs2), .rd(mem_wb_q.rd),
    .we(mem_wb_q.reg_write), .wdata(mem_wb_q.value), .rdata1(rdata1), .rdata2(rdata2)
  );

  always_comb begin
    id_ex_d         = '0;
    id_ex_d.ctrl    = id_ctrl;
    id_ex_d.pc      = if_id_q.pc;
    id_ex_d.rs1_val = rdata1;
    id_ex_d.rs2_val = rdata2;
    id_ex_d.imm     = id_imm;
    id_ex_d.rs1     = id_rs1;
    id_ex_d.rs2     = id_rs2;
    id_ex_d.rd      = id_rd;
  end

  pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk(clk), .reset(reset), .en(pipe_en), .flush(id_ex_flush), .d(id_ex_d), .q(id_ex_q)
  );

  // execute
  execute_unit i_execute_unit (
    .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(ex_mem_q.result),
    .wb_value(mem_wb_q.value), .ex_mem(ex_mem_d), .redirect(redirect), .target(target)
  );

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk(clk), .reset(reset), .en(pipe_en), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
  );

  // memory, nothing reaches dmem once frozen
  assign dmem_req.rd    = ex_mem_q.mem_read && pipe_en;
  assign dmem_req.wr    = ex_mem_q.mem_write && pipe_en;
  assign dmem_req.addr  = ex_mem_q.result;
  assign dmem_req.wdata = ex_mem_q.store_data;

  always_comb begin
    mem_wb_d           = '0;
    mem_wb_d.reg_write = ex_mem_q.reg_write;
    mem_wb_d.is_halt   = ex_mem_q.is_halt;
    mem_wb_d.rd        = ex_mem_q.rd;
    mem_wb_d.value     = ex_mem_q.mem_read ? dmem_rsp.rdata : ex_mem_q.result; // load or alu
  end

  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk(clk), .reset(reset), .en(pipe_en), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
  );

  hazard_unit i_hazard_unit (
    .clk(clk), .reset(reset), .id_rs1(id_rs1), .id_rs2(id_rs2),
    .id_ex_bits(id_ex_q), .ex_mem_bits(ex_mem_q), .mem_wb_bits(mem_wb_q),
    .redirect(redirect), .pc_en(pc_en), .if_id_en(if_id_en), .pipe_en(pipe_en),
    .if_id_flush(if_id_flush), .id_ex_flush(id_ex_flush),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .halted(halted)
  );

endmodule

`default_nettype wire

//--- verilog/rv_isa_pkg.sv
// RV32I subset only: add sub and or slt addi lw sw beq bne jal ecall
`include "core_defs.svh"
`default_nettype none

package rv_isa_pkg;

  typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_IMM    = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_R      = 7'b0110011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  localparam logic [2:0] F3_ADD_SUB = 3'b000; // add, sub, addi
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_WORD    = 3'b010; // lw and sw
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // add must stay zero, a bubble decodes to add
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src_imm; // operand b from imm
    logic    is_branch;
    logic    branch_ne;   // bne, else beq
    logic    is_jal;
    logic    is_ecall;
    alu_op_e alu_op;
  } ctrl_t;

endpackage

`default_nettype wire
